//--- hw/soc_bus_pkg.sv
package soc_bus_pkg;

  //*********************************************************************
  // bus widths
  //*********************************************************************

  localparam int unsigned APB_ADDR_WIDTH = 32;
  localparam int unsigned APB_DATA_WIDTH = 32;

  // peripheral side follows the APB port one to one
  localparam int unsigned PER_ADDR_WIDTH = APB_ADDR_WIDTH;
  localparam int unsigned PER_DATA_WIDTH = APB_DATA_WIDTH;

  //*********************************************************************
  // APB debug port
  //*********************************************************************

  typedef struct packed {
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  //*********************************************************************
  // peripheral bus, grant implied
  //*********************************************************************

  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [PER_ADDR_WIDTH-1:0] addr;
    logic [PER_DATA_WIDTH-1:0] wdata;
  } per_req_t;

  typedef struct packed {
    logic                      r_valid;
    logic [PER_DATA_WIDTH-1:0] r_rdata;
    logic                      r_err;
  } per_rsp_t;

endpackage

//--- hw/dbg_pkg.sv
package dbg_pkg;

  //*********************************************************************
  // harts and debug module sizing
  //*********************************************************************

  localparam int unsigned NR_HARTS = 4;

  // one bit per hart that actually exists
  localparam logic [NR_HARTS-1:0] SELECTABLE_HARTS = 4'b0101;

  localparam int unsigned DATA_COUNT = 2;
  localparam logic [11:0] DATA_ADDR  = 12'h004;
  localparam int unsigned NSCRATCH   = 2;

  //*********************************************************************
  // register map, offsets within paddr[11:0]
  //*********************************************************************

  localparam logic [11:0] REG_HARTINFO  = 12'h000;
  localparam logic [11:0] REG_DATA0     = 12'h004;
  localparam logic [11:0] REG_DATA1     = 12'h008;
  localparam logic [11:0] REG_HALTREQ   = 12'h00C;
  localparam logic [11:0] REG_EVT_COUNT = 12'h010;

  // reset values
  localparam logic [31:0]         DATA_RST_VALUE      = 32'h0000_0000;
  localparam logic [NR_HARTS-1:0] HALTREQ_RST_VALUE   = '0;
  localparam logic [31:0]         EVT_COUNT_RST_VALUE = 32'h0000_0000;

  //*********************************************************************
  // hart info word
  //*********************************************************************

  typedef struct packed {
    logic [7:0]  zero1;
    logic [3:0]  nscratch;
    logic [2:0]  zero0;
    logic        dataaccess;
    logic [3:0]  datasize;
    logic [11:0] dataaddr;
  } hartinfo_t;

  // built by fields, read back as a plain bus word
  typedef union packed {
    hartinfo_t   fields;
    logic [31:0] raw;
  } hartinfo_u;

  // nscratch 2, memory mapped data, two data words at 0x004
  localparam logic [31:0] HARTINFO_VALUE = 32'h0021_2004;

endpackage

//--- hw/apb_per_bridge.sv
`timescale 1ns/1ps

module apb_per_bridge
  import soc_bus_pkg::*;
(
  input  logic     s_soc_clk,
  input  logic     s_soc_rstn,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output per_req_t per_req_o,
  input  per_rsp_t per_rsp_i
);

  logic access;
  logic issued_q;
  logic rsp_pend_q;
  logic pready;

  // psel and penable both high means an access cycle
  assign access = apb_req_i.psel & apb_req_i.penable;

  //*********************************************************************
  // request side
  //*********************************************************************

  // strobe only in the first access cycle, grant is implied
  always_comb begin
    per_req_o.req   = access & ~issued_q;
    per_req_o.we    = apb_req_i.pwrite;
    per_req_o.addr  = apb_req_i.paddr;
    per_req_o.wdata = apb_req_i.pwdata;
  end

  // marks the transfer as sent until pready goes back
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      issued_q <= 1'b0;
    end else if (pready) begin
      issued_q <= 1'b0;
    end else if (per_req_o.req) begin
      issued_q <= 1'b1;
    end
  end

  //*********************************************************************
  // response side
  //*********************************************************************

  // one response expected in the cycle after each strobe
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      rsp_pend_q <= 1'b0;
    end else begin
      rsp_pend_q <= per_req_o.req;
    end
  end

  assign pready = rsp_pend_q & per_rsp_i.r_valid;

  always_comb begin
    apb_rsp_o.pready  = pready;
    apb_rsp_o.pslverr = pready & per_rsp_i.r_err;
    // bus idles at zero between transfers
    apb_rsp_o.prdata  = pready ? per_rsp_i.r_rdata : '0;
  end

endmodule

//--- hw/pf_evt_sync.sv
`timescale 1ns/1ps

module pf_evt_sync (
  input  logic s_soc_clk,
  input  logic s_soc_rstn,
  input  logic pf_evt_valid_i,
  output logic pf_evt_ack_o,
  output logic evt_pulse_o
);

  logic [1:0] sync_q;
  logic       level_q;

  //*********************************************************************
  // two-flop synchronizer plus edge flop
  //*********************************************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      sync_q  <= 2'b00;
      level_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], pf_evt_valid_i};
      level_q <= sync_q[1];
    end
  end

  // ack tracks the synchronized level, four-phase on the far side
  assign pf_evt_ack_o = sync_q[1];

  // one pulse per rising edge of the level
  assign evt_pulse_o = sync_q[1] & ~level_q;

endmodule

//--- hw/dbg_regs.sv
`timescale 1ns/1ps

module dbg_regs
  import soc_bus_pkg::*;
  import dbg_pkg::*;
(
  input  logic                s_soc_clk,
  input  logic                s_soc_rstn,
  input  per_req_t            per_req_i,
  output per_rsp_t            per_rsp_o,
  input  logic                evt_pulse_i,
  output logic [NR_HARTS-1:0] debug_req_o
);

  logic [11:0]               offset;
  logic                      mapped;
  logic [PER_DATA_WIDTH-1:0] rdata;
  hartinfo_u                 hartinfo;

  logic [DATA_COUNT-1:0][PER_DATA_WIDTH-1:0] data_q;
  logic [NR_HARTS-1:0]                       haltreq_q;
  logic [31:0]                               evt_count_q;

  // write held for one cycle, committed at the end of the second access cycle
  logic                      wr_pend_q;
  logic [11:0]               wr_offset_q;
  logic [PER_DATA_WIDTH-1:0] wr_data_q;

  logic                      r_valid_q;
  logic                      r_err_q;
  logic [PER_DATA_WIDTH-1:0] r_rdata_q;

  // upper address bits ignored
  assign offset = per_req_i.addr[11:0];

  always_comb begin
    hartinfo.fields = '{
      zero1:      '0,
      nscratch:   4'(NSCRATCH),
      zero0:      '0,
      dataaccess: 1'b1,
      datasize:   4'(DATA_COUNT),
      dataaddr:   DATA_ADDR
    };
  end

  //*********************************************************************
  // decode and read mux
  //*********************************************************************

  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (offset)
      REG_HARTINFO:  rdata = hartinfo.raw;
      REG_DATA0:     rdata = data_q[0];
      REG_DATA1:     rdata = data_q[1];
      REG_HALTREQ:   rdata = {{(PER_DATA_WIDTH - NR_HARTS){1'b0}}, haltreq_q};
      REG_EVT_COUNT: rdata = evt_count_q;
      default:       mapped = 1'b0;
    endcase
  end

  //*********************************************************************
  // response, one cycle after the strobe
  //*********************************************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      r_valid_q <= 1'b0;
      r_err_q   <= 1'b0;
    end else begin
      r_valid_q <= per_req_i.req;
      r_err_q   <= per_req_i.req & ~mapped;
    end
  end

  always_ff @(posedge s_soc_clk) begin
    if (per_req_i.req) begin
      r_rdata_q <= rdata;
    end
  end

  assign per_rsp_o.r_valid = r_valid_q;
  assign per_rsp_o.r_rdata = r_rdata_q;
  assign per_rsp_o.r_err   = r_err_q;

  //*********************************************************************
  // writes
  //*********************************************************************

  // unmapped writes never become pending
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      wr_pend_q <= 1'b0;
    end else begin
      wr_pend_q <= per_req_i.req & per_req_i.we & mapped;
    end
  end

  always_ff @(posedge s_soc_clk) begin
    if (per_req_i.req) begin
      wr_offset_q <= offset;
      wr_data_q   <= per_req_i.wdata;
    end
  end

  // hart info and event count are read only
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      data_q    <= {DATA_COUNT{DATA_RST_VALUE}};
      haltreq_q <= HALTREQ_RST_VALUE;
    end else if (wr_pend_q) begin
      case (wr_offset_q)
        REG_DATA0:   data_q[0] <= wr_data_q;
        REG_DATA1:   data_q[1] <= wr_data_q;
        REG_HALTREQ: haltreq_q <= wr_data_q[NR_HARTS-1:0] & SELECTABLE_HARTS;
        default:     ;
      endcase
    end
  end

  assign debug_req_o = haltreq_q;

  // external events
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      evt_count_q <= EVT_COUNT_RST_VALUE;
    end else if (evt_pulse_i) begin
      evt_count_q <= evt_count_q + 32'd1;
    end
  end

endmodule

//--- hw/soc_debug_top.sv
`timescale 1ns/1ps

module soc_debug_top
  import soc_bus_pkg::*;
  import dbg_pkg::*;
(
  input  logic                s_soc_clk,
  input  logic                s_soc_rstn,
  input  apb_req_t            apb_req_i,
  output apb_rsp_t            apb_rsp_o,
  input  logic                pf_evt_valid_i,
  output logic                pf_evt_ack_o,
  output logic [NR_HARTS-1:0] debug_req_o
);

  //*********************************************************************
  // internal wiring
  //*********************************************************************

  per_req_t per_req;
  per_rsp_t per_rsp;
  logic     evt_pulse;

  // APB port into the debug register block
  apb_per_bridge i_apb_per_bridge (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .per_req_o  (per_req),
    .per_rsp_i  (per_rsp)
  );

  // event level from outside the domain
  pf_evt_sync i_pf_evt_sync (
    .s_soc_clk      (s_soc_clk),
    .s_soc_rstn     (s_soc_rstn),
    .pf_evt_valid_i (pf_evt_valid_i),
    .pf_evt_ack_o   (pf_evt_ack_o),
    .evt_pulse_o    (evt_pulse)
  );

  dbg_regs i_dbg_regs (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .per_req_i   (per_req),
    .per_rsp_o   (per_rsp),
    .evt_pulse_i (evt_pulse),
    .debug_req_o (debug_req_o)
  );

endmodule

//--- bench/soc_debug_asserts.sv
`timescale 1ns/1ps

module soc_debug_asserts
  import soc_bus_pkg::*;
  import dbg_pkg::*;
(
  input logic                s_soc_clk,
  input logic                s_soc_rstn,
  input apb_req_t            apb_req_i,
  input apb_rsp_t            apb_rsp_i,
  input logic                pf_evt_valid_i,
  input logic                pf_evt_ack_i,
  input logic [NR_HARTS-1:0] debug_req_i
);

  // read by the testbench to end the run
  int unsigned fail_count = 0;

  //*********************************************************************
  // APB access phases
  //*********************************************************************

  // setup, first access, then pready in the second access
  pready_second_access_a: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable)
      && $past(apb_req_i.psel && apb_req_i.penable)
      && $past(apb_req_i.psel && !apb_req_i.penable, 2))
    else begin
      fail_count++;
      $error("pready outside the second access cycle");
    end

  pslverr_with_pready_a: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp_i.pslverr |-> apb_rsp_i.pready)
    else begin
      fail_count++;
      $error("pslverr without pready");
    end

  //*********************************************************************
  // debug requests and event handshake
  //*********************************************************************

  halt_mask_a: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    (debug_req_i & ~SELECTABLE_HARTS) == '0)
    else begin
      fail_count++;
      $error("debug request on a hart that does not exist");
    end

  // ack is valid seen through two flops
  evt_ack_delay_a: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    pf_evt_ack_i == $past(pf_evt_valid_i, 2))
    else begin
      fail_count++;
      $error("event ack does not follow valid by two cycles");
    end

endmodule

bind soc_debug_top soc_debug_asserts i_soc_debug_asserts (
  .s_soc_clk      (s_soc_clk),
  .s_soc_rstn     (s_soc_rstn),
  .apb_req_i      (apb_req_i),
  .apb_rsp_i      (apb_rsp_o),
  .pf_evt_valid_i (pf_evt_valid_i),
  .pf_evt_ack_i   (pf_evt_ack_o),
  .debug_req_i    (debug_req_o)
);

//--- bench/tb_soc_debug.sv
`timescale 1ns/1ps

module tb_soc_debug
  import soc_bus_pkg::*;
  import dbg_pkg::*;
();

  localparam int unsigned TIMEOUT_CYCLES = 2000;
  localparam int unsigned WAIT_LIMIT     = 16;

  logic                s_soc_clk;
  logic                s_soc_rstn;
  apb_req_t            apb_req;
  apb_rsp_t            apb_rsp;
  logic                pf_evt_valid;
  logic                pf_evt_ack;
  logic [NR_HARTS-1:0] debug_req;

  int                  seed;
  int unsigned         cycle_count;
  int unsigned         n_events;
  logic [31:0]         addr;
  logic [31:0]         exp_rdata;
  logic                exp_err;
  logic [31:0]         exp_data [DATA_COUNT];
  logic [NR_HARTS-1:0] exp_haltreq;
  logic [31:0]         exp_evt_count;

  soc_debug_top uut (
    .s_soc_clk      (s_soc_clk),
    .s_soc_rstn     (s_soc_rstn),
    .apb_req_i      (apb_req),
    .apb_rsp_o      (apb_rsp),
    .pf_evt_valid_i (pf_evt_valid),
    .pf_evt_ack_o   (pf_evt_ack),
    .debug_req_o    (debug_req)
  );

  always #50 s_soc_clk = ~s_soc_clk;

  task automatic value_error(input string msg);
    $display("** Error at %0d ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic run_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  always @(posedge s_soc_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      run_error("run did not finish within the cycle limit");
    end
  end

  always @(negedge s_soc_clk) begin
    if (uut.i_soc_debug_asserts.fail_count != 0) begin
      run_error("a bound protocol assertion failed");
    end
  end

  //*********************************************************************
  // response checks against the register model
  //*********************************************************************

  read_data_a: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp.pready && !apb_req.pwrite |-> apb_rsp.prdata == exp_rdata)
    else value_error($sformatf("read data %h, expected %h",
                               $sampled(apb_rsp.prdata), exp_rdata));

  slverr_a: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp.pready |-> apb_rsp.pslverr == exp_err)
    else value_error($sformatf("pslverr %b, expected %b", $sampled(apb_rsp.pslverr), exp_err));

  // error responses carry no data
  err_data_zero_a: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp.pslverr |-> apb_rsp.prdata == '0)
    else value_error("prdata not zero on an error response");

  function automatic logic [31:0] model_value(input logic [11:0] off);
    case (off)
      REG_HARTINFO:  return 32'h0021_2004;
      REG_DATA0:     return exp_data[0];
      REG_DATA1:     return exp_data[1];
      REG_HALTREQ:   return {28'h0, exp_haltreq};
      REG_EVT_COUNT: return exp_evt_count;
      default:       return 32'h0;
    endcase
  endfunction

  function automatic logic in_map(input logic [11:0] off);
    return off inside {REG_HARTINFO, REG_DATA0, REG_DATA1, REG_HALTREQ, REG_EVT_COUNT};
  endfunction

  //*********************************************************************
  // APB master entered and left just after a falling edge
  //*********************************************************************

  task automatic apb_transfer(input logic wr, input logic [31:0] a, input logic [31:0] wdata);
    int unsigned n_access;
    logic        done;
    apb_req.paddr   = a;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = wdata;
    @(negedge s_soc_clk);
    apb_req.penable = 1'b1;
    n_access = 0;
    done     = 1'b0;
    while (!done) begin
      n_access++;
      if (n_access > WAIT_LIMIT) begin
        run_error("no pready within the access wait limit");
      end
      done = apb_rsp.pready;
      @(negedge s_soc_clk);
    end
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    assert (n_access == 2)
      else value_error($sformatf("pready in access cycle %0d, expected 2", n_access));
  endtask

  task automatic apb_read(input logic [31:0] a);
    exp_err   = !in_map(a[11:0]);
    exp_rdata = model_value(a[11:0]);
    apb_transfer(1'b0, a, 32'h0);
  endtask

  task automatic apb_write(input logic [31:0] a, input logic [31:0] wdata);
    exp_err = !in_map(a[11:0]);
    apb_transfer(1'b1, a, wdata);
    case (a[11:0])
      REG_DATA0:   exp_data[0] = wdata;
      REG_DATA1:   exp_data[1] = wdata;
      REG_HALTREQ: exp_haltreq = wdata[NR_HARTS-1:0] & 4'b0101;
      default:     ;
    endcase
  endtask

  // one four-phase valid/ack handshake followed by an idle gap
  task automatic event_handshake(input int unsigned gap);
    int unsigned waited;
    pf_evt_valid = 1'b1;
    waited = 0;
    while (!pf_evt_ack) begin
      @(negedge s_soc_clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        run_error("event ack did not rise");
      end
    end
    pf_evt_valid = 1'b0;
    exp_evt_count = exp_evt_count + 1;
    waited = 0;
    while (pf_evt_ack) begin
      @(negedge s_soc_clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        run_error("event ack did not fall");
      end
    end
    repeat (gap) @(negedge s_soc_clk);
  endtask

  task automatic read_all_mapped();
    apb_read(REG_HARTINFO);
    apb_read(REG_DATA0);
    apb_read(REG_DATA1);
    apb_read(REG_HALTREQ);
    apb_read(REG_EVT_COUNT);
  endtask

  //*********************************************************************
  // test sequence
  //*********************************************************************

  initial begin
    seed          = 32'hcc68_0462;
    cycle_count   = 0;
    s_soc_clk     = 1'b0;
    s_soc_rstn    = 1'b0;
    apb_req       = '0;
    pf_evt_valid  = 1'b0;
    exp_rdata     = '0;
    exp_err       = 1'b0;
    exp_data[0]   = '0;
    exp_data[1]   = '0;
    exp_haltreq   = '0;
    exp_evt_count = '0;
    repeat (8) @(negedge s_soc_clk);
    s_soc_rstn = 1'b1;

    assert (!apb_rsp.pready && !apb_rsp.pslverr && !pf_evt_ack && debug_req == '0)
      else value_error("outputs not idle after reset");
    read_all_mapped();

    // hart info is read only
    apb_write(REG_HARTINFO, $random(seed));
    apb_read(REG_HARTINFO);

    repeat (20) begin
      addr = ($random(seed) & 1) ? REG_DATA1 : REG_DATA0;
      apb_write(addr, $random(seed));
      apb_read(addr);
    end

    repeat (8) begin
      apb_write(REG_HALTREQ, $random(seed));
      assert (debug_req == exp_haltreq)
        else value_error($sformatf("debug_req %b, expected %b", debug_req, exp_haltreq));
      apb_read(REG_HALTREQ);
    end

    // unmapped offsets and one address with upper bits set
    apb_write(32'h0000_0014, $random(seed));
    apb_write(32'h0000_0FFC, $random(seed));
    apb_read(32'h0000_0014);
    apb_read(32'h5A00_0FFC);
    assert (debug_req == exp_haltreq)
      else value_error("debug_req changed by an unmapped write");
    read_all_mapped();

    n_events = 1 + ($unsigned($random(seed)) % 8);
    repeat (n_events) event_handshake($unsigned($random(seed)) % 4);
    apb_read(REG_EVT_COUNT);
    @(negedge s_soc_clk);

    if (uut.i_soc_debug_asserts.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "protocol assertions failed during the run");
    end
  end

endmodule

//--- tb.f
hw/soc_bus_pkg.sv
hw/dbg_pkg.sv
hw/apb_per_bridge.sv
hw/pf_evt_sync.sv
hw/dbg_regs.sv
hw/soc_debug_top.sv
bench/soc_debug_asserts.sv
bench/tb_soc_debug.sv
